// File: src/memPkg.sv
package memPkg;

	// Word and address widths
	localparam int dataWidth = 18;
	localparam int addrWidth = 14;

	// One bank is 1024 words
	localparam int bankAddrWidth = 10;
	localparam int bankDepth = 1 << bankAddrWidth;

	// Upper address bits pick the bank, only 0 to 10 are populated
	localparam int bankSelWidth = addrWidth - bankAddrWidth;
	localparam int bankCount = 11;

endpackage

// File: src/isaPkg.sv
package isaPkg;

	localparam int opWidth = 4;

	////////////////////////////////////////
	// Opcodes
	// Any other value is a no-op
	////////////////////////////////////////
	localparam logic [opWidth-1:0] opHalt = 4'd0;
	localparam logic [opWidth-1:0] opLdi = 4'd1;
	localparam logic [opWidth-1:0] opAddi = 4'd2;
	localparam logic [opWidth-1:0] opLda = 4'd3;
	localparam logic [opWidth-1:0] opSta = 4'd4;
	localparam logic [opWidth-1:0] opAdd = 4'd5;
	localparam logic [opWidth-1:0] opSub = 4'd6;
	localparam logic [opWidth-1:0] opJmp = 4'd7;
	localparam logic [opWidth-1:0] opJz = 4'd8;

	// First instruction fetched after a start
	localparam logic [memPkg::addrWidth-1:0] resetVector = '0;

	////////////////////////////////////////
	// Instruction word
	////////////////////////////////////////
	typedef struct packed {
		logic [opWidth-1:0] opcode;
		logic [memPkg::addrWidth-1:0] addr;
	} memRefFields;

	// Low field read as a two's complement constant
	typedef struct packed {
		logic [opWidth-1:0] opcode;
		logic signed [memPkg::addrWidth-1:0] imm;
	} immedFields;

	typedef union packed {
		memRefFields memRef;
		immedFields immed;
	} instrWord;

endpackage

// File: src/BlockRam.sv
`timescale 1ns/1ns

module BlockRam (
	input logic clka,
	input logic wea,
	input logic web,
	input logic [memPkg::bankAddrWidth-1:0] addra,
	input logic [memPkg::bankAddrWidth-1:0] addrb,
	input logic [memPkg::dataWidth-1:0] dina,
	input logic [memPkg::dataWidth-1:0] dinb,
	output logic [memPkg::dataWidth-1:0] douta,
	output logic [memPkg::dataWidth-1:0] doutb
);

	logic [memPkg::dataWidth-1:0] mem [memPkg::bankDepth];

	// Port A, read returns the word before the write
	always @(posedge clka)
	begin
		if (wea)
			mem[addra] <= dina;
		douta <= mem[addra];
	end

	// Port B
	always @(posedge clka)
	begin
		if (web)
			mem[addrb] <= dinb;
		doutb <= mem[addrb];
	end

endmodule

// File: src/MainMem.sv
`timescale 1ns/1ns

module MainMem (
	input logic clka,
	input logic wea,
	input logic web,
	input logic [memPkg::addrWidth-1:0] addra,
	input logic [memPkg::addrWidth-1:0] addrb,
	input logic [memPkg::dataWidth-1:0] dina,
	input logic [memPkg::dataWidth-1:0] dinb,
	output logic [memPkg::dataWidth-1:0] douta,
	output logic [memPkg::dataWidth-1:0] doutb
);

	logic [memPkg::bankSelWidth-1:0] bankA;
	logic [memPkg::bankSelWidth-1:0] bankB;
	logic [memPkg::bankSelWidth-1:0] bankADelayed;
	logic [memPkg::bankSelWidth-1:0] bankBDelayed;

	logic [memPkg::bankCount-1:0] weaBank;
	logic [memPkg::bankCount-1:0] webBank;
	logic [memPkg::dataWidth-1:0] doutaBank [memPkg::bankCount];
	logic [memPkg::dataWidth-1:0] doutbBank [memPkg::bankCount];

	assign bankA = addra[memPkg::addrWidth-1 -: memPkg::bankSelWidth];
	assign bankB = addrb[memPkg::addrWidth-1 -: memPkg::bankSelWidth];

	////////////////////////////////////////
	// Banks
	////////////////////////////////////////
	genvar i;
	for (i = 0; i < memPkg::bankCount; i++)
	begin : bank
		// Selects past bank 10 match nothing, so the write is dropped
		assign weaBank[i] = wea && (bankA == i);
		assign webBank[i] = web && (bankB == i);

		BlockRam ram (
			.clka(clka),
			.wea(weaBank[i]),
			.web(webBank[i]),
			.addra(addra[memPkg::bankAddrWidth-1:0]),
			.addrb(addrb[memPkg::bankAddrWidth-1:0]),
			.dina(dina),
			.dinb(dinb),
			.douta(doutaBank[i]),
			.doutb(doutbBank[i])
		);
	end

	////////////////////////////////////////
	// Read select
	////////////////////////////////////////

	// Follows the RAM output register by one clock
	always_ff @(posedge clka)
	begin
		bankADelayed <= bankA;
		bankBDelayed <= bankB;
	end

	always_comb
	begin
		douta = '0;
		doutb = '0;
		if (bankADelayed < memPkg::bankCount)
			douta = doutaBank[bankADelayed];
		if (bankBDelayed < memPkg::bankCount)
			doutb = doutbBank[bankBDelayed];
	end

endmodule

// File: src/fetchStage.sv
`timescale 1ns/1ns

module fetchStage (
	input logic clka,
	input logic arstN,
	input logic run,
	input logic hostWe,
	input logic [memPkg::addrWidth-1:0] hostAddr,
	input logic [memPkg::dataWidth-1:0] hostDin,
	input logic execDone,
	input logic jumpTaken,
	input logic [memPkg::addrWidth-1:0] jumpAddr,
	input logic haltSeen,
	output logic memAWe,
	output logic [memPkg::addrWidth-1:0] memAAddr,
	output logic [memPkg::dataWidth-1:0] memADin,
	output logic fetchValid,
	output logic halted
);

	logic runD;
	logic start;
	logic hostOwns;
	logic [memPkg::addrWidth-1:0] pc;
	logic [memPkg::addrWidth-1:0] fetchAddr;

	////////////////////////////////////////
	// Next fetch
	////////////////////////////////////////
	always_comb
	begin
		// Only a fresh rise of run restarts the core
		start = run && !runD && halted;
		fetchValid = start || (execDone && !haltSeen);

		if (start)
			fetchAddr = isaPkg::resetVector;
		else if (jumpTaken)
			fetchAddr = jumpAddr;
		else
			fetchAddr = pc + 1'b1;
	end

	// Port A ownership
	always_comb
	begin
		hostOwns = halted && !run;
		memAWe = hostOwns && hostWe;
		memAAddr = hostOwns ? hostAddr : fetchAddr;
		memADin = hostDin;
	end

	always_ff @(posedge clka or negedge arstN)
	begin
		if (!arstN)
		begin
			runD <= 1'b0;
			pc <= '0;
			halted <= 1'b1;
		end
		else
		begin
			runD <= run;
			if (fetchValid)
				pc <= fetchAddr;
			if (start)
				halted <= 1'b0;
			else if (execDone && haltSeen)
				halted <= 1'b1;
		end
	end

endmodule

// File: src/operandStage.sv
`timescale 1ns/1ns

module operandStage (
	input logic clka,
	input logic arstN,
	input logic fetchValid,
	input isaPkg::instrWord instr,
	input logic [memPkg::dataWidth-1:0] acc,
	output logic memBWe,
	output logic [memPkg::addrWidth-1:0] memBAddr,
	output logic [memPkg::dataWidth-1:0] memBDin,
	output logic opValid,
	output isaPkg::instrWord opInstr
);

	// High in the cycle the fetched word sits on port A
	logic instrLive;
	logic usesMem;

	////////////////////////////////////////
	// Port B issue
	////////////////////////////////////////
	always_comb
	begin
		case (instr.memRef.opcode)
			isaPkg::opLda,
			isaPkg::opAdd,
			isaPkg::opSub,
			isaPkg::opSta: usesMem = 1'b1;
			default: usesMem = 1'b0;
		endcase

		memBAddr = usesMem ? instr.memRef.addr : '0;
		memBWe = instrLive && (instr.memRef.opcode == isaPkg::opSta);
		memBDin = acc;
	end

	always_ff @(posedge clka or negedge arstN)
	begin
		if (!arstN)
		begin
			instrLive <= 1'b0;
			opValid <= 1'b0;
		end
		else
		begin
			instrLive <= fetchValid;
			opValid <= instrLive;
		end
	end

	// Instruction register
	always_ff @(posedge clka)
	begin
		if (instrLive)
			opInstr <= instr;
	end

endmodule

// File: src/executeStage.sv
`timescale 1ns/1ns

module executeStage (
	input logic clka,
	input logic arstN,
	input logic opValid,
	input isaPkg::instrWord opInstr,
	input logic [memPkg::dataWidth-1:0] operand,
	output logic [memPkg::dataWidth-1:0] acc,
	output logic execDone,
	output logic jumpTaken,
	output logic [memPkg::addrWidth-1:0] jumpAddr,
	output logic haltSeen
);

	logic signed [memPkg::dataWidth-1:0] immExt;
	logic accZero;

	// Immediate view, sign extended to a full word
	always_comb
	begin
		immExt = opInstr.immed.imm;
		accZero = (acc == '0);
	end

	////////////////////////////////////////
	// ALU and branch
	////////////////////////////////////////
	always_ff @(posedge clka or negedge arstN)
	begin
		if (!arstN)
		begin
			acc <= '0;
			execDone <= 1'b0;
			jumpTaken <= 1'b0;
			haltSeen <= 1'b0;
		end
		else
		begin
			execDone <= opValid;
			jumpTaken <= 1'b0;
			haltSeen <= 1'b0;
			if (opValid)
			begin
				case (opInstr.memRef.opcode)
					isaPkg::opHalt: haltSeen <= 1'b1;
					isaPkg::opLdi: acc <= immExt;
					isaPkg::opAddi: acc <= acc + immExt;
					isaPkg::opLda: acc <= operand;
					isaPkg::opAdd: acc <= acc + operand;
					isaPkg::opSub: acc <= acc - operand;
					isaPkg::opJmp: jumpTaken <= 1'b1;
					isaPkg::opJz: jumpTaken <= accZero;
					// opSta only writes memory
					default: acc <= acc;
				endcase
			end
		end
	end

	// Target from the address view
	always_ff @(posedge clka)
	begin
		if (opValid)
			jumpAddr <= opInstr.memRef.addr;
	end

endmodule

// File: src/cpuSystem.sv
`timescale 1ns/1ns

module cpuSystem (
	input logic clka,
	input logic arstN,
	input logic run,
	input logic hostWe,
	input logic [memPkg::addrWidth-1:0] hostAddr,
	input logic [memPkg::dataWidth-1:0] hostDin,
	output logic [memPkg::dataWidth-1:0] hostDout,
	output logic halted,
	output logic [memPkg::dataWidth-1:0] acc
);

	////////////////////////////////////////
	// Interconnect
	////////////////////////////////////////
	logic memAWe;
	logic [memPkg::addrWidth-1:0] memAAddr;
	logic [memPkg::dataWidth-1:0] memADin;
	logic memBWe;
	logic [memPkg::addrWidth-1:0] memBAddr;
	logic [memPkg::dataWidth-1:0] memBDin;
	logic [memPkg::dataWidth-1:0] operand;

	logic fetchValid;
	logic opValid;
	logic [memPkg::dataWidth-1:0] opInstr;
	logic execDone;
	logic jumpTaken;
	logic [memPkg::addrWidth-1:0] jumpAddr;
	logic haltSeen;

	fetchStage fetch (
		.clka(clka),
		.arstN(arstN),
		.run(run),
		.hostWe(hostWe),
		.hostAddr(hostAddr),
		.hostDin(hostDin),
		.execDone(execDone),
		.jumpTaken(jumpTaken),
		.jumpAddr(jumpAddr),
		.haltSeen(haltSeen),
		.memAWe(memAWe),
		.memAAddr(memAAddr),
		.memADin(memADin),
		.fetchValid(fetchValid),
		.halted(halted)
	);

	// Port A data is both the fetched word and the host read
	operandStage operandSt (
		.clka(clka),
		.arstN(arstN),
		.fetchValid(fetchValid),
		.instr(hostDout),
		.acc(acc),
		.memBWe(memBWe),
		.memBAddr(memBAddr),
		.memBDin(memBDin),
		.opValid(opValid),
		.opInstr(opInstr)
	);

	executeStage execute (
		.clka(clka),
		.arstN(arstN),
		.opValid(opValid),
		.opInstr(opInstr),
		.operand(operand),
		.acc(acc),
		.execDone(execDone),
		.jumpTaken(jumpTaken),
		.jumpAddr(jumpAddr),
		.haltSeen(haltSeen)
	);

	MainMem mem (
		.clka(clka),
		.wea(memAWe),
		.web(memBWe),
		.addra(memAAddr),
		.addrb(memBAddr),
		.dina(memADin),
		.dinb(memBDin),
		.douta(hostDout),
		.doutb(operand)
	);

endmodule

// File: tb/cpuSystemTb.sv
`timescale 1ns/1ns

module cpuSystemTb;

	localparam int kindWrite = 0;
	localparam int kindRead = 1;
	localparam int kindRun = 2;
	localparam int kindAcc = 3;
	localparam int haltTimeout = 2000;
	localparam int counterAddr = 'h0800;
	localparam int sumAddr = 'h0801;

	logic clka;
	logic arstN;
	logic run;
	logic hostWe;
	logic [memPkg::addrWidth-1:0] hostAddr;
	logic [memPkg::dataWidth-1:0] hostDin;
	logic [memPkg::dataWidth-1:0] hostDout;
	logic halted;
	logic [memPkg::dataWidth-1:0] acc;

	// One stimulus row per test
	int rowKind [$];
	logic [memPkg::addrWidth-1:0] rowAddr [$];
	logic [memPkg::dataWidth-1:0] rowData [$];
	logic [31:0] rowExp [$];

	// Expected memory image
	logic [memPkg::dataWidth-1:0] shadow [0:(1 << memPkg::addrWidth)-1];

	int passCount;
	int failCount;
	int cycles;
	bit ok;
	bit timedOut;

	cpuSystem uut (.*);

	initial clka = 1'b0;
	always #50 clka = ~clka;

	function automatic logic [memPkg::dataWidth-1:0] encode(logic [isaPkg::opWidth-1:0] op,
		int field);
		isaPkg::instrWord w;
		w.immed.opcode = op;
		w.immed.imm = field[memPkg::addrWidth-1:0];
		return w;
	endfunction

	function automatic logic [memPkg::addrWidth-1:0] place(int bank, int offset);
		return {bank[memPkg::bankSelWidth-1:0], offset[memPkg::bankAddrWidth-1:0]};
	endfunction

	// Banks 11 to 15 do not exist
	function automatic bit inBank(logic [memPkg::addrWidth-1:0] a);
		return a[memPkg::addrWidth-1 -: memPkg::bankSelWidth] < memPkg::bankCount;
	endfunction

	task automatic writeRow(input logic [memPkg::addrWidth-1:0] a,
		input logic [memPkg::dataWidth-1:0] d);
		rowKind.push_back(kindWrite);
		rowAddr.push_back(a);
		rowData.push_back(d);
		rowExp.push_back(0);
		if (inBank(a))
			shadow[a] = d;
	endtask

	task automatic readRow(input logic [memPkg::addrWidth-1:0] a);
		rowKind.push_back(kindRead);
		rowAddr.push_back(a);
		rowData.push_back(0);
		rowExp.push_back(inBank(a) ? shadow[a] : 0);
	endtask

	// Every instruction takes three cycles
	task automatic runRow(input int instrCount);
		rowKind.push_back(kindRun);
		rowAddr.push_back(0);
		rowData.push_back(0);
		rowExp.push_back(3 * instrCount);
	endtask

	task automatic accRow(input logic [memPkg::dataWidth-1:0] e);
		rowKind.push_back(kindAcc);
		rowAddr.push_back(0);
		rowData.push_back(0);
		rowExp.push_back(e);
	endtask

	////////////////////////////////////////
	// Table
	////////////////////////////////////////
	task automatic buildTable();
		int immA;
		int immB;
		int v1;
		int v2;
		int arith;
		int n;
		int sum;
		int steps;
		int d;
		logic [memPkg::addrWidth-1:0] randAddr [8];
		for (int j = 0; j < (1 << memPkg::addrWidth); j++)
			shadow[j] = '0;
		accRow(0);
		for (int b = 0; b < 11; b++)
			writeRow(place(b, b * 37 + 3), 18'((b + 1) * 4099));
		for (int b = 0; b < 11; b++)
			readRow(place(b, b * 37 + 3));
		// Same offsets as banks 3 to 7, which differ only in the top select bit
		for (int b = 11; b < 16; b++)
			writeRow(place(b, (b - 8) * 37 + 3), 18'h3ffff);
		for (int b = 11; b < 16; b++)
			readRow(place(b, (b - 8) * 37 + 3));
		for (int b = 0; b < 11; b++)
			readRow(place(b, b * 37 + 3));

		// Arithmetic program
		immA = -5;
		immB = 100;
		v1 = 1000;
		v2 = 3000;
		writeRow('h0410, v1[17:0]);
		writeRow('h0411, v2[17:0]);
		writeRow(0, encode(isaPkg::opLdi, immA));
		writeRow(1, encode(isaPkg::opAddi, immB));
		writeRow(2, encode(isaPkg::opAdd, 'h0410));
		writeRow(3, encode(isaPkg::opSub, 'h0411));
		writeRow(4, encode(isaPkg::opSta, 'h0412));
		writeRow(5, encode(isaPkg::opHalt, 0));
		runRow(6);
		arith = immA + immB + v1 - v2;
		accRow(arith[17:0]);
		shadow['h0412] = arith[17:0];
		readRow('h0412);

		// Count down to zero while summing the counter
		n = 5;
		writeRow(counterAddr, n[17:0]);
		writeRow(sumAddr, 0);
		writeRow(0, encode(isaPkg::opLda, counterAddr));
		writeRow(1, encode(isaPkg::opJz, 9));
		writeRow(2, encode(isaPkg::opAdd, sumAddr));
		writeRow(3, encode(isaPkg::opSta, sumAddr));
		writeRow(4, encode(isaPkg::opLda, counterAddr));
		writeRow(5, encode(isaPkg::opAddi, -1));
		writeRow(6, encode(isaPkg::opSta, counterAddr));
		writeRow(7, encode(isaPkg::opJmp, 0));
		writeRow(9, encode(isaPkg::opLda, sumAddr));
		writeRow(10, encode(isaPkg::opHalt, 0));
		sum = 0;
		steps = 4;
		for (int k = n; k > 0; k--)
		begin
			sum += k;
			steps += 8;
		end
		runRow(steps);
		accRow(sum[17:0]);
		shadow[sumAddr] = sum[17:0];
		shadow[counterAddr] = '0;
		readRow(sumAddr);
		readRow(counterAddr);

		for (int k = 0; k < 8; k++)
		begin
			randAddr[k] = place($urandom % memPkg::bankCount, $urandom % memPkg::bankDepth);
			d = $urandom;
			writeRow(randAddr[k], d[17:0]);
		end
		for (int k = 0; k < 8; k++)
			readRow(randAddr[k]);
	endtask

	task automatic applyRow(input int i);
		ok = 1'b1;
		case (rowKind[i])
			kindWrite:
			begin
				hostWe = 1'b1;
				hostAddr = rowAddr[i];
				hostDin = rowData[i];
				@(posedge clka);
				#5;
				hostWe = 1'b0;
			end
			kindRead:
			begin
				hostAddr = rowAddr[i];
				@(posedge clka);
				#5;
				if ({14'b0, hostDout} !== rowExp[i])
				begin
					$display("CHECK FAILED at %0t: read 0x%h from 0x%h, expected 0x%h",
						$time, hostDout, rowAddr[i], rowExp[i][17:0]);
					ok = 1'b0;
				end
			end
			kindRun:
			begin
				run = 1'b1;
				cycles = 0;
				@(posedge clka);
				#5;
				// Halted is sampled once per cycle while the core runs
				while (!halted && cycles < haltTimeout)
				begin
					cycles++;
					@(posedge clka);
					#5;
				end
				if (!halted)
				begin
					$display("Core did not halt within %0d cycles", haltTimeout);
					timedOut = 1'b1;
					ok = 1'b0;
				end
				else if (cycles != rowExp[i])
				begin
					$display("CHECK FAILED at %0t: halted low for %0d cycles, expected %0d",
						$time, cycles, rowExp[i]);
					ok = 1'b0;
				end
				run = 1'b0;
			end
			default:
			begin
				if ({14'b0, acc} !== rowExp[i] || halted !== 1'b1)
				begin
					$display("CHECK FAILED at %0t: acc 0x%h halted %b, expected acc 0x%h",
						$time, acc, halted, rowExp[i][17:0]);
					ok = 1'b0;
				end
			end
		endcase
		if (ok)
			passCount++;
		else
			failCount++;
		$display("Test %0d kind %0d %s", i, rowKind[i], ok ? "passed" : "FAILED");
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial
	begin
		void'($urandom(84));
		arstN = 1'b0;
		run = 1'b0;
		hostWe = 1'b0;
		hostAddr = '0;
		hostDin = '0;
		passCount = 0;
		failCount = 0;
		timedOut = 1'b0;
		buildTable();
		repeat (2) @(posedge clka);
		#5;
		arstN = 1'b1;
		for (int i = 0; i < rowKind.size() && !timedOut; i++)
			applyRow(i);
		$display("%0d tests passed, %0d tests failed", passCount, failCount);
		if (failCount == 0 && !timedOut)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: cpuSystem.f
src/memPkg.sv
src/isaPkg.sv
src/BlockRam.sv
src/MainMem.sv
src/fetchStage.sv
src/operandStage.sv
src/executeStage.sv
src/cpuSystem.sv
tb/cpuSystemTb.sv

// File: Bender.yml
package:
  name: cpusystem

sources:
  - src/memPkg.sv
  - src/isaPkg.sv
  - src/BlockRam.sv
  - src/MainMem.sv
  - src/fetchStage.sv
  - src/operandStage.sv
  - src/executeStage.sv
  - src/cpuSystem.sv
  - target: simulation
    files:
      - tb/cpuSystemTb.sv
